//--- compile.f
+incdir+.
user_pkg.sv
user_addr_decode.sv
user_obi_demux.sv
user_gpio_regs.sv
user_timer.sv
user_err_sbr.sv
user_domain.sv
tb_user_domain.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_user_domain \
  -f compile.f -o sim_tb_user_domain
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb_user_domain)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Verification passed"; then
  exit 0
fi
exit 1

//--- tb_user_domain.sv
`timescale 1ns/1ps
`include "user_settings.svh"

module tb_user_domain;

  import user_pkg::*;

  localparam int unsigned dw = `USER_DATA_WIDTH;
  localparam int unsigned gc = `USER_GPIO_COUNT;
  localparam int half_period  = 20;
  localparam int sample_delay = 5;
  localparam int gnt_timeout  = 8;
  localparam logic [31:0] gpio_base  = `USER_GPIO_BASE;
  localparam logic [31:0] timer_base = `USER_TIMER_BASE;

  logic                        clk_i;
  logic                        reset_i;
  logic                        req_i;
  logic                        gnt_o;
  logic [`USER_ADDR_WIDTH-1:0] addr_i;
  logic                        we_i;
  logic [`USER_DATA_WIDTH-1:0] wdata_i;
  logic                        rvalid_o;
  logic [`USER_DATA_WIDTH-1:0] rdata_o;
  logic                        err_o;
  logic [`USER_GPIO_COUNT-1:0] gpio_in_sync_i;
  logic [`USER_GPIO_COUNT-1:0] gpio_out_o;
  logic [`USER_NUM_IRQS-1:0]   interrupts_o;

  // Pending requests and expected responses in arrival order
  logic [31:0] rq_addr [$];
  bit          rq_we [$];
  logic [31:0] rq_wdata [$];
  logic [31:0] exp_data [$];
  bit          exp_err [$];

  // Register model
  logic [gc-1:0]    m_gpio_out;
  logic [gc-1:0]    m_irq_en;
  logic [gc-1:0]    m_irq_status;
  user_timer_ctrl_u m_ctrl;
  logic [31:0]      m_compare;
  logic             m_tmr_status;

  string cur_test;
  int    test_errors;
  int    total_errors;
  int    tests_run;
  int    tests_failed;

  user_domain dut0 (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .req_i          (req_i),
    .gnt_o          (gnt_o),
    .addr_i         (addr_i),
    .we_i           (we_i),
    .wdata_i        (wdata_i),
    .rvalid_o       (rvalid_o),
    .rdata_o        (rdata_o),
    .err_o          (err_o),
    .gpio_in_sync_i (gpio_in_sync_i),
    .gpio_out_o     (gpio_out_o),
    .interrupts_o   (interrupts_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(half_period) clk_i = ~clk_i;
  end

  // Hard stop in case a loop misbehaves
  initial begin
    #(half_period * 2 * 50000);
    $display("Watchdog expired before the tests completed");
    $display("Verification failed");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Bookkeeping
  // ----------------------------------------------------------------------
  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
    end
    total_errors += test_errors;
    $display("TEST %-12s %s (%0d errors)", cur_test, (test_errors == 0) ? "PASS" : "FAIL",
             test_errors);
  endtask

  task automatic report_problem(input string msg);
    $display("ERROR in %s: %s", cur_test, msg);
    test_errors++;
  endtask

  task automatic compare_word(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
    assert (act === exp) else begin
      $display("CHECK FAILED %s %s expected %h actual %h", cur_test, what, exp, act);
      test_errors++;
    end
  endtask

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------

  // Address map from the region table
  function automatic user_sbr_idx_e region_of(input logic [31:0] a);
    if (a >= `USER_GPIO_BASE && a <= `USER_GPIO_END) begin
      return USER_GPIO;
    end
    if (a >= `USER_TIMER_BASE && a <= `USER_TIMER_END) begin
      return USER_TIMER;
    end
    return USER_ERROR;
  endfunction

  // Predicts the response for one granted access and applies writes
  task automatic model_access(input logic [31:0] a, input bit w, input logic [31:0] wd,
                              output logic [31:0] rd, output bit er);
    logic [9:0] off;
    off = a[11:2];
    rd  = '0;
    er  = 1'b0;
    case (region_of(a))
      USER_GPIO: begin
        if (w) begin
          if (off == 10'd1) m_gpio_out = wd[gc-1:0];
          if (off == 10'd2) m_irq_en = wd[gc-1:0];
          if (off == 10'd3) m_irq_status = m_irq_status & ~wd[gc-1:0];
        end else begin
          case (off)
            10'd0:   rd = dw'(gpio_in_sync_i);
            10'd1:   rd = dw'(m_gpio_out);
            10'd2:   rd = dw'(m_irq_en);
            10'd3:   rd = dw'(m_irq_status);
            default: rd = '0;
          endcase
        end
      end
      USER_TIMER: begin
        if (w) begin
          if (off == 10'd0) begin
            m_ctrl.raw             = wd;
            m_ctrl.fields.reserved = '0;
          end
          if (off == 10'd2) m_compare = wd;
          if (off == 10'd3 && wd[0]) m_tmr_status = 1'b0;
        end else begin
          // COUNT stays zero while the timer has never run
          case (off)
            10'd0:   rd = m_ctrl.raw;
            10'd2:   rd = m_compare;
            10'd3:   rd = dw'(m_tmr_status);
            default: rd = '0;
          endcase
        end
      end
      default: begin
        rd = `USER_ERR_RSP_DATA;
        er = 1'b1;
      end
    endcase
  endtask

  // ----------------------------------------------------------------------
  // Bus driver
  // ----------------------------------------------------------------------
  task automatic queue_access(input logic [31:0] a, input bit w, input logic [31:0] wd);
    rq_addr.push_back(a);
    rq_we.push_back(w);
    rq_wdata.push_back(wd);
  endtask

  // Issue queued requests back to back with one response per grant a cycle later
  task automatic run_requests();
    int          n;
    int          idx;
    int          waited;
    int          cycles;
    int          inflight;
    logic [31:0] pd;
    bit          pe;
    logic [31:0] ed;
    bit          ee;
    n      = rq_addr.size();
    idx    = 0;
    waited = 0;
    cycles = 0;
    while (idx < n || exp_data.size() > 0) begin
      @(negedge clk_i);
      if (idx < n) begin
        req_i   = 1'b1;
        addr_i  = rq_addr[idx];
        we_i    = rq_we[idx];
        wdata_i = rq_wdata[idx];
      end else begin
        req_i   = 1'b0;
        addr_i  = '0;
        we_i    = 1'b0;
        wdata_i = '0;
      end
      #(sample_delay);
      // Transactions still counted by the demux in this cycle
      inflight = exp_data.size();
      // Response to last cycle's grant
      if (exp_data.size() > 0) begin
        ed = exp_data.pop_front();
        ee = exp_err.pop_front();
        assert (rvalid_o === 1'b1) else report_problem("no response one cycle after grant");
        if (rvalid_o === 1'b1) begin
          compare_word("rdata", ed, rdata_o);
          compare_word("err", 32'(ee), 32'(err_o));
        end
      end else begin
        assert (rvalid_o === 1'b0) else report_problem("response with nothing outstanding");
      end
      compare_word("gpio_out", dw'(m_gpio_out), dw'(gpio_out_o));
      if (req_i === 1'b1) begin
        // Grant only while the in-order queue has room
        compare_word("gnt", 32'(inflight < `USER_MAX_TRANS), 32'(gnt_o));
      end
      if (req_i === 1'b1 && gnt_o === 1'b1) begin
        model_access(addr_i, we_i, wdata_i, pd, pe);
        exp_data.push_back(pd);
        exp_err.push_back(pe);
        idx++;
        waited = 0;
      end else if (req_i === 1'b1) begin
        waited++;
        if (waited > gnt_timeout) begin
          report_problem("timeout waiting for gnt");
          idx = n;
        end
      end
      cycles++;
      if (cycles > n * 4 + 20) begin
        report_problem("request sequence did not finish in time");
        idx = n;
        exp_data.delete();
        exp_err.delete();
      end
    end
    rq_addr.delete();
    rq_we.delete();
    rq_wdata.delete();
  endtask

  task automatic wait_irq(input int line, input int limit, output bit seen);
    int k;
    seen = 1'b0;
    for (k = 0; k < limit && !seen; k++) begin
      @(negedge clk_i);
      #(sample_delay);
      if (interrupts_o[line] === 1'b1) seen = 1'b1;
    end
  endtask

  // Random address outside both peripheral ranges
  function automatic logic [31:0] random_unmapped();
    logic [31:0] a;
    do begin
      a = $urandom();
    end while (region_of(a) != USER_ERROR);
    return a;
  endfunction

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    logic [31:0]      a;
    logic [31:0]      tmp;
    logic [9:0]       off;
    bit               w;
    bit               seen;
    int               i;
    int               sel;
    int               en_bit;
    int               dis_bit;
    int               presc;
    int               cmp;
    int               bound;
    user_timer_ctrl_u ctrl_w;

    reset_i        = 1'b1;
    req_i          = 1'b0;
    addr_i         = '0;
    we_i           = 1'b0;
    wdata_i        = '0;
    gpio_in_sync_i = '0;
    m_gpio_out     = '0;
    m_irq_en       = '0;
    m_irq_status   = '0;
    m_ctrl.raw     = '0;
    m_compare      = '0;
    m_tmr_status   = 1'b0;
    total_errors   = 0;
    tests_run      = 0;
    tests_failed   = 0;
    void'($urandom(20));
    // Constant pin pattern keeps edges out of the register tests
    gpio_in_sync_i = gc'($urandom());

    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    start_test("reset_state");
    #(sample_delay);
    compare_word("interrupts", 32'h0, 32'(interrupts_o));
    compare_word("gpio_out", 32'h0, dw'(gpio_out_o));
    compare_word("rvalid", 32'h0, 32'(rvalid_o));
    // Queue starts empty
    compare_word("gnt", 32'h1, 32'(gnt_o));
    queue_access(gpio_base + 32'h4, 1'b0, '0);
    queue_access(timer_base, 1'b0, '0);
    run_requests();
    finish_test();

    start_test("reg_access");
    for (i = 0; i < 24; i++) begin
      sel = $urandom_range(3, 0);
      tmp = $urandom();
      case (sel)
        0: a = gpio_base + 32'h4;
        1: a = gpio_base + 32'h8;
        2: a = timer_base + 32'h8;
        default: begin
          // Unused offset in either region
          off = 10'($urandom_range(1023, 4));
          a   = ($urandom_range(1, 0) == 1) ? timer_base : gpio_base;
          a   = a + {20'h0, off, 2'b00};
        end
      endcase
      queue_access(a, 1'b1, tmp);
      queue_access(a, 1'b0, '0);
      run_requests();
    end
    finish_test();

    start_test("error_region");
    queue_access(32'h1FFF_FFFC, 1'b0, '0);
    queue_access(32'h2000_2000, 1'b1, $urandom());
    for (i = 0; i < 16; i++) begin
      w = 1'($urandom_range(1, 0));
      queue_access(random_unmapped(), w, $urandom());
    end
    run_requests();
    // Peripheral registers read back untouched
    queue_access(gpio_base + 32'h4, 1'b0, '0);
    queue_access(gpio_base + 32'h8, 1'b0, '0);
    queue_access(timer_base + 32'h8, 1'b0, '0);
    run_requests();
    finish_test();

    start_test("back_to_back");
    for (i = 0; i < 40; i++) begin
      sel = $urandom_range(2, 0);
      off = 10'($urandom_range(5, 0));
      w   = 1'($urandom_range(1, 0));
      tmp = $urandom();
      case (sel)
        0: a = gpio_base + {20'h0, off, 2'b00};
        1: begin
          a = timer_base + {20'h0, off, 2'b00};
          // Keep the timer stopped
          if (off == 10'd0) w = 1'b0;
        end
        default: a = random_unmapped();
      endcase
      queue_access(a, w, tmp);
    end
    run_requests();
    finish_test();

    start_test("gpio_irq");
    @(negedge clk_i);
    gpio_in_sync_i = '0;
    repeat (2) @(negedge clk_i);
    en_bit  = $urandom_range(gc - 1, 0);
    dis_bit = (en_bit + 1 + $urandom_range(gc - 2, 0)) % gc;
    queue_access(gpio_base + 32'hC, 1'b1, 32'hFFFF_FFFF);
    queue_access(gpio_base + 32'h8, 1'b1, 32'h1 << en_bit);
    run_requests();
    // Disabled pin goes high first and must not latch
    @(negedge clk_i);
    gpio_in_sync_i[dis_bit] = 1'b1;
    for (i = 0; i < 4; i++) begin
      @(negedge clk_i);
      #(sample_delay);
      compare_word("irq0 disabled pin", 32'h0, 32'(interrupts_o[0]));
    end
    queue_access(gpio_base + 32'hC, 1'b0, '0);
    run_requests();
    @(negedge clk_i);
    gpio_in_sync_i[en_bit] = 1'b1;
    wait_irq(0, 8, seen);
    assert (seen) else report_problem("GPIO interrupt did not rise within 8 cycles");
    m_irq_status[en_bit] = 1'b1;
    queue_access(gpio_base + 32'hC, 1'b0, '0);
    queue_access(gpio_base + 32'hC, 1'b1, 32'h1 << en_bit);
    run_requests();
    compare_word("irq0 after clear", 32'h0, 32'(interrupts_o[0]));
    queue_access(gpio_base + 32'hC, 1'b0, '0);
    run_requests();
    finish_test();

    start_test("timer_irq");
    presc = $urandom_range(3, 1);
    cmp   = $urandom_range(5, 2);
    // Ticks every presc+1 cycles and hits on tick number cmp+1
    bound = (cmp + 1) * (presc + 1) + 8;
    ctrl_w.raw               = '0;
    ctrl_w.fields.enable     = 1'b1;
    ctrl_w.fields.irq_enable = 1'b1;
    ctrl_w.fields.prescale   = 8'(presc);
    queue_access(timer_base + 32'h8, 1'b1, 32'(cmp));
    queue_access(timer_base, 1'b1, ctrl_w.raw);
    run_requests();
    wait_irq(1, bound, seen);
    assert (seen) else report_problem("timer interrupt did not rise within the bound");
    m_tmr_status = 1'b1;
    ctrl_w.fields.enable = 1'b0;
    queue_access(timer_base + 32'hC, 1'b0, '0);
    queue_access(timer_base, 1'b1, ctrl_w.raw);
    queue_access(timer_base + 32'hC, 1'b1, 32'h1);
    run_requests();
    compare_word("irq1 after clear", 32'h0, 32'(interrupts_o[1]));
    // Running with the interrupt masked
    ctrl_w.fields.enable     = 1'b1;
    ctrl_w.fields.irq_enable = 1'b0;
    queue_access(timer_base, 1'b1, ctrl_w.raw);
    run_requests();
    for (i = 0; i < 2 * bound; i++) begin
      @(negedge clk_i);
      #(sample_delay);
      compare_word("irq1 masked", 32'h0, 32'(interrupts_o[1]));
    end
    m_tmr_status = 1'b1;
    queue_access(timer_base + 32'hC, 1'b0, '0);
    queue_access(timer_base, 1'b1, 32'h0);
    queue_access(timer_base + 32'hC, 1'b1, 32'h1);
    run_requests();
    finish_test();

    $display("Tests: %0d run, %0d passed, %0d failed, %0d check errors", tests_run,
             tests_run - tests_failed, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- user_addr_decode.sv
`timescale 1ns/1ps
`include "user_settings.svh"

module user_addr_decode (
  input  logic [`USER_ADDR_WIDTH-1:0] addr_i,
  output user_pkg::user_sbr_idx_e     idx_o
);

  import user_pkg::*;

  // Rule table, one entry per mapped peripheral
  localparam int unsigned num_rules = 2;

  localparam logic [`USER_ADDR_WIDTH-1:0] rule_start [num_rules] = '{
    `USER_GPIO_BASE,
    `USER_TIMER_BASE
  };
  localparam logic [`USER_ADDR_WIDTH-1:0] rule_end [num_rules] = '{
    `USER_GPIO_END,
    `USER_TIMER_END
  };
  localparam user_sbr_idx_e rule_idx [num_rules] = '{USER_GPIO, USER_TIMER};

  // Inclusive range match
  // anything unmatched lands on the error subordinate
  always_comb begin
    idx_o = USER_ERROR;
    for (int unsigned i = 0; i < num_rules; i++) begin
      if (addr_i >= rule_start[i] && addr_i <= rule_end[i]) begin
        idx_o = rule_idx[i];
      end
    end
  end

endmodule

//--- user_domain.sv
`timescale 1ns/1ps
`include "user_settings.svh"

module user_domain (
  input  logic                        clk_i,
  input  logic                        reset_i,
  // Subordinate bus from the core
  input  logic                        req_i,
  output logic                        gnt_o,
  input  logic [`USER_ADDR_WIDTH-1:0] addr_i,
  input  logic                        we_i,
  input  logic [`USER_DATA_WIDTH-1:0] wdata_i,
  output logic                        rvalid_o,
  output logic [`USER_DATA_WIDTH-1:0] rdata_o,
  output logic                        err_o,
  // Pins and interrupts
  input  logic [`USER_GPIO_COUNT-1:0] gpio_in_sync_i,
  output logic [`USER_GPIO_COUNT-1:0] gpio_out_o,
  output logic [`USER_NUM_IRQS-1:0]   interrupts_o
);

  import user_pkg::*;

  user_sbr_idx_e sbr_idx;

  // ----------------------------------------------------------------------
  // Per-subordinate bus wires
  // ----------------------------------------------------------------------
  logic                        err_req;
  logic                        err_gnt;
  logic                        err_rvalid;
  logic [`USER_DATA_WIDTH-1:0] err_rdata;
  logic                        err_err;

  logic                        gpio_req;
  logic                        gpio_gnt;
  logic                        gpio_rvalid;
  logic [`USER_DATA_WIDTH-1:0] gpio_rdata;
  logic                        gpio_err;

  logic                        timer_req;
  logic                        timer_gnt;
  logic                        timer_rvalid;
  logic [`USER_DATA_WIDTH-1:0] timer_rdata;
  logic                        timer_err;

  // Address map lookup
  user_addr_decode i_addr_decode (
    .addr_i (addr_i),
    .idx_o  (sbr_idx)
  );

  // Steering and in-order response return
  user_obi_demux i_obi_demux (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .req_i              (req_i),
    .gnt_o              (gnt_o),
    .idx_i              (sbr_idx),
    .rvalid_o           (rvalid_o),
    .rdata_o            (rdata_o),
    .err_o              (err_o),
    .sbr_err_req_o      (err_req),
    .sbr_err_gnt_i      (err_gnt),
    .sbr_err_rvalid_i   (err_rvalid),
    .sbr_err_rdata_i    (err_rdata),
    .sbr_err_err_i      (err_err),
    .sbr_gpio_req_o     (gpio_req),
    .sbr_gpio_gnt_i     (gpio_gnt),
    .sbr_gpio_rvalid_i  (gpio_rvalid),
    .sbr_gpio_rdata_i   (gpio_rdata),
    .sbr_gpio_err_i     (gpio_err),
    .sbr_timer_req_o    (timer_req),
    .sbr_timer_gnt_i    (timer_gnt),
    .sbr_timer_rvalid_i (timer_rvalid),
    .sbr_timer_rdata_i  (timer_rdata),
    .sbr_timer_err_i    (timer_err)
  );

  // ----------------------------------------------------------------------
  // Subordinates, addr/we/wdata shared by all
  // ----------------------------------------------------------------------

  // Interrupt bit 0
  user_gpio_regs i_gpio (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .req_i      (gpio_req),
    .gnt_o      (gpio_gnt),
    .addr_i     (addr_i),
    .we_i       (we_i),
    .wdata_i    (wdata_i),
    .rvalid_o   (gpio_rvalid),
    .rdata_o    (gpio_rdata),
    .err_o      (gpio_err),
    .gpio_in_i  (gpio_in_sync_i),
    .gpio_out_o (gpio_out_o),
    .irq_o      (interrupts_o[0])
  );

  // Interrupt bit 1
  user_timer i_timer (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (timer_req),
    .gnt_o    (timer_gnt),
    .addr_i   (addr_i),
    .we_i     (we_i),
    .wdata_i  (wdata_i),
    .rvalid_o (timer_rvalid),
    .rdata_o  (timer_rdata),
    .err_o    (timer_err),
    .irq_o    (interrupts_o[1])
  );

  // Catches all unmapped addresses
  user_err_sbr i_err (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (err_req),
    .gnt_o    (err_gnt),
    .rvalid_o (err_rvalid),
    .rdata_o  (err_rdata),
    .err_o    (err_err)
  );

endmodule

//--- user_err_sbr.sv
`timescale 1ns/1ps
`include "user_settings.svh"

module user_err_sbr (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        req_i,
  output logic                        gnt_o,
  output logic                        rvalid_o,
  output logic [`USER_DATA_WIDTH-1:0] rdata_o,
  output logic                        err_o
);

  localparam logic [`USER_DATA_WIDTH-1:0] rsp_data = `USER_ERR_RSP_DATA;

  logic rvalid_q;

  // Accept everything
  assign gnt_o = 1'b1;

  // One response per accepted request, next cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  // Every response flags an error
  // reads and writes both see the fixed pattern
  assign rvalid_o = rvalid_q;
  assign err_o    = rvalid_q;
  assign rdata_o  = rvalid_q ? rsp_data : '0;

endmodule

//--- user_gpio_regs.sv
`timescale 1ns/1ps
`include "user_settings.svh"

module user_gpio_regs (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        req_i,
  output logic                        gnt_o,
  input  logic [`USER_ADDR_WIDTH-1:0] addr_i,
  input  logic                        we_i,
  input  logic [`USER_DATA_WIDTH-1:0] wdata_i,
  output logic                        rvalid_o,
  output logic [`USER_DATA_WIDTH-1:0] rdata_o,
  output logic                        err_o,
  input  logic [`USER_GPIO_COUNT-1:0] gpio_in_i,
  output logic [`USER_GPIO_COUNT-1:0] gpio_out_o,
  output logic                        irq_o
);

  localparam int unsigned gc = `USER_GPIO_COUNT;
  localparam int unsigned dw = `USER_DATA_WIDTH;

  // Word indices within the 4 KiB region
  localparam logic [9:0] reg_in     = 10'd0;
  localparam logic [9:0] reg_out    = 10'd1;
  localparam logic [9:0] reg_irq_en = 10'd2;
  localparam logic [9:0] reg_irq_st = 10'd3;

  logic [9:0]    word_idx;
  logic          wr_en;
  logic [gc-1:0] gpio_out_q;
  logic [gc-1:0] irq_en_q;
  logic [gc-1:0] irq_status_q;
  logic [gc-1:0] gpio_in_q;
  logic [gc-1:0] rise;
  logic [gc-1:0] clr;
  logic [dw-1:0] rd_val;
  logic          rvalid_q;
  logic [dw-1:0] rdata_q;

  // Always ready
  assign gnt_o    = 1'b1;
  assign word_idx = addr_i[11:2];
  assign wr_en    = req_i & we_i;

  // Rising edge on enabled pins only
  assign rise = gpio_in_i & ~gpio_in_q & irq_en_q;
  // Write one to clear
  assign clr  = (wr_en && word_idx == reg_irq_st) ? wdata_i[gc-1:0] : '0;

  // Read mux where unused offsets read zero
  always_comb begin
    case (word_idx)
      reg_in:     rd_val = dw'(gpio_in_i);
      reg_out:    rd_val = dw'(gpio_out_q);
      reg_irq_en: rd_val = dw'(irq_en_q);
      reg_irq_st: rd_val = dw'(irq_status_q);
      default:    rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      gpio_out_q   <= '0;
      irq_en_q     <= '0;
      irq_status_q <= '0;
      gpio_in_q    <= '0;
      rvalid_q     <= 1'b0;
    end else begin
      gpio_in_q <= gpio_in_i;
      rvalid_q  <= req_i;
      if (wr_en && word_idx == reg_out) begin
        gpio_out_q <= wdata_i[gc-1:0];
      end
      if (wr_en && word_idx == reg_irq_en) begin
        irq_en_q <= wdata_i[gc-1:0];
      end
      // New edge wins over a clear in the same cycle
      irq_status_q <= (irq_status_q & ~clr) | rise;
    end
  end

  // Read data captured on each accepted request
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= we_i ? '0 : rd_val;
    end
  end

  assign rvalid_o   = rvalid_q;
  assign rdata_o    = rdata_q;
  assign err_o      = 1'b0;
  assign gpio_out_o = gpio_out_q;
  assign irq_o      = |irq_status_q;

endmodule

//--- user_obi_demux.sv
`timescale 1ns/1ps
`include "user_settings.svh"

module user_obi_demux (
  input  logic                        clk_i,
  input  logic                        reset_i,
  // Upstream port
  input  logic                        req_i,
  output logic                        gnt_o,
  input  user_pkg::user_sbr_idx_e     idx_i,
  output logic                        rvalid_o,
  output logic [`USER_DATA_WIDTH-1:0] rdata_o,
  output logic                        err_o,
  // Error subordinate
  output logic                        sbr_err_req_o,
  input  logic                        sbr_err_gnt_i,
  input  logic                        sbr_err_rvalid_i,
  input  logic [`USER_DATA_WIDTH-1:0] sbr_err_rdata_i,
  input  logic                        sbr_err_err_i,
  // GPIO subordinate
  output logic                        sbr_gpio_req_o,
  input  logic                        sbr_gpio_gnt_i,
  input  logic                        sbr_gpio_rvalid_i,
  input  logic [`USER_DATA_WIDTH-1:0] sbr_gpio_rdata_i,
  input  logic                        sbr_gpio_err_i,
  // Timer subordinate
  output logic                        sbr_timer_req_o,
  input  logic                        sbr_timer_gnt_i,
  input  logic                        sbr_timer_rvalid_i,
  input  logic [`USER_DATA_WIDTH-1:0] sbr_timer_rdata_i,
  input  logic                        sbr_timer_err_i
);

  import user_pkg::*;

  localparam int unsigned max_trans = `USER_MAX_TRANS;
  localparam int unsigned ptr_w     = (max_trans > 1) ? $clog2(max_trans) : 1;
  localparam int unsigned cnt_w     = $clog2(max_trans + 1);

  // In-order queue of transaction targets
  user_sbr_idx_e    q_idx [max_trans];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] count_q;

  logic          full;
  logic          sel_gnt;
  logic          push;
  logic          pop;
  logic          head_rvalid;
  user_sbr_idx_e head_idx;

  assign full = (count_q == cnt_w'(max_trans));

  // ----------------------------------------------------------------------
  // Request side
  // ----------------------------------------------------------------------

  // Only the indexed subordinate sees req, held off while queue is full
  always_comb begin
    sbr_err_req_o   = 1'b0;
    sbr_gpio_req_o  = 1'b0;
    sbr_timer_req_o = 1'b0;
    sel_gnt         = 1'b0;
    case (idx_i)
      USER_GPIO: begin
        sbr_gpio_req_o = req_i & ~full;
        sel_gnt        = sbr_gpio_gnt_i;
      end
      USER_TIMER: begin
        sbr_timer_req_o = req_i & ~full;
        sel_gnt         = sbr_timer_gnt_i;
      end
      default: begin
        sbr_err_req_o = req_i & ~full;
        sel_gnt       = sbr_err_gnt_i;
      end
    endcase
  end

  assign gnt_o = sel_gnt & ~full;
  assign push  = req_i & gnt_o;

  // ----------------------------------------------------------------------
  // Response side
  // ----------------------------------------------------------------------

  // Oldest outstanding target picks the response
  assign head_idx = q_idx[rd_ptr_q];

  always_comb begin
    case (head_idx)
      USER_GPIO: begin
        head_rvalid = sbr_gpio_rvalid_i;
        rdata_o     = sbr_gpio_rdata_i;
        err_o       = sbr_gpio_err_i;
      end
      USER_TIMER: begin
        head_rvalid = sbr_timer_rvalid_i;
        rdata_o     = sbr_timer_rdata_i;
        err_o       = sbr_timer_err_i;
      end
      default: begin
        head_rvalid = sbr_err_rvalid_i;
        rdata_o     = sbr_err_rdata_i;
        err_o       = sbr_err_err_i;
      end
    endcase
  end

  // Ignore stray rvalid with nothing in flight
  assign rvalid_o = (count_q != '0) & head_rvalid;
  assign pop      = rvalid_o;

  // Queue storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      q_idx[wr_ptr_q] <= idx_i;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(max_trans - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(max_trans - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Push and pop together leave the count alone
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

//--- user_pkg.sv
`include "user_settings.svh"

package user_pkg;

  // Demux target index, error subordinate is the fallback
  typedef enum logic [1:0] {
    USER_ERROR = 2'd0,
    USER_GPIO  = 2'd1,
    USER_TIMER = 2'd2
  } user_sbr_idx_e;

  // Timer CTRL fields, LSB first from the bottom
  typedef struct packed {
    logic [`USER_DATA_WIDTH-11:0] reserved;
    logic [7:0]                   prescale;
    logic                         irq_enable;
    logic                         enable;
  } user_timer_ctrl_fields_t;

  // Same CTRL word
  // raw view for bus access, fields view for the counter logic
  typedef union packed {
    logic [`USER_DATA_WIDTH-1:0] raw;
    user_timer_ctrl_fields_t     fields;
  } user_timer_ctrl_u;

endpackage

//--- user_settings.svh
`ifndef USER_SETTINGS_SVH
`define USER_SETTINGS_SVH

// ----------------------------------------------------------------------
// Bus widths
// ----------------------------------------------------------------------
`define USER_ADDR_WIDTH 32
`define USER_DATA_WIDTH 32

// Peripheral sizing
`define USER_GPIO_COUNT 16
// Bit 0 GPIO, bit 1 timer
`define USER_NUM_IRQS 2

// ----------------------------------------------------------------------
// Address map, inclusive ranges
// ----------------------------------------------------------------------
`define USER_GPIO_BASE  32'h2000_0000
`define USER_GPIO_END   32'h2000_0FFF
`define USER_TIMER_BASE 32'h2000_1000
`define USER_TIMER_END  32'h2000_1FFF

// Outstanding transactions in the demux
`define USER_MAX_TRANS 2

// Read data for unmapped addresses
`define USER_ERR_RSP_DATA 32'hBADC_AB1E

`endif

//--- user_timer.sv
`timescale 1ns/1ps
`include "user_settings.svh"

module user_timer (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        req_i,
  output logic                        gnt_o,
  input  logic [`USER_ADDR_WIDTH-1:0] addr_i,
  input  logic                        we_i,
  input  logic [`USER_DATA_WIDTH-1:0] wdata_i,
  output logic                        rvalid_o,
  output logic [`USER_DATA_WIDTH-1:0] rdata_o,
  output logic                        err_o,
  output logic                        irq_o
);

  import user_pkg::*;

  localparam int unsigned dw = `USER_DATA_WIDTH;

  // Word indices within the region
  localparam logic [9:0] reg_ctrl    = 10'd0;
  localparam logic [9:0] reg_count   = 10'd1;
  localparam logic [9:0] reg_compare = 10'd2;
  localparam logic [9:0] reg_status  = 10'd3;

  logic [9:0]       word_idx;
  logic             wr_en;
  user_timer_ctrl_u ctrl_q;
  user_timer_ctrl_u ctrl_d;
  logic [dw-1:0]    count_q;
  logic [dw-1:0]    compare_q;
  logic             status_q;
  logic [7:0]       presc_q;
  logic             tick;
  logic             match;
  logic             clr;
  logic [dw-1:0]    rd_val;
  logic             rvalid_q;
  logic [dw-1:0]    rdata_q;

  assign gnt_o    = 1'b1;
  assign word_idx = addr_i[11:2];
  assign wr_en    = req_i & we_i;

  // Capture raw word, reserved field forced to zero
  always_comb begin
    ctrl_d.raw             = wdata_i;
    ctrl_d.fields.reserved = '0;
  end

  // ----------------------------------------------------------------------
  // Prescaler and counter
  // ----------------------------------------------------------------------

  // One tick every prescale+1 enabled cycles
  assign tick  = ctrl_q.fields.enable && (presc_q == ctrl_q.fields.prescale);
  assign match = (count_q == compare_q);
  assign clr   = wr_en && (word_idx == reg_status) && wdata_i[0];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ctrl_q.raw <= '0;
      compare_q  <= '0;
      count_q    <= '0;
      presc_q    <= '0;
      status_q   <= 1'b0;
      rvalid_q   <= 1'b0;
    end else begin
      rvalid_q <= req_i;
      if (wr_en && word_idx == reg_ctrl) begin
        ctrl_q <= ctrl_d;
      end
      if (wr_en && word_idx == reg_compare) begin
        compare_q <= wdata_i;
      end
      // Prescaler parked at zero while disabled
      if (!ctrl_q.fields.enable || tick) begin
        presc_q <= '0;
      end else begin
        presc_q <= presc_q + 1'b1;
      end
      if (tick) begin
        count_q <= match ? '0 : count_q + 1'b1;
      end
      // Set on compare hit beats a W1C
      status_q <= (status_q & ~clr) | (tick & match);
    end
  end

  always_comb begin
    case (word_idx)
      reg_ctrl:    rd_val = ctrl_q.raw;
      reg_count:   rd_val = count_q;
      reg_compare: rd_val = compare_q;
      reg_status:  rd_val = dw'(status_q);
      default:     rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= we_i ? '0 : rd_val;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign err_o    = 1'b0;
  assign irq_o    = status_q & ctrl_q.fields.irq_enable;

endmodule
